//--- cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// direct-mapped L1 geometry, 16-byte lines
`define L1_SETS  8    // sets per cache
`define INDEX_W  3    // log2 of L1_SETS
`define OFFSET_W 4    // byte within line
`define TAG_W    9    // 16 - INDEX_W - OFFSET_W

`endif

//--- lc3b_types.sv
package lc3b_types;

    // basic LC-3b datapath unit
    typedef logic [15:0] lc3b_word;

    // byte enables, bit 0 = low byte
    typedef logic [1:0] lc3b_mem_wmask;

    typedef logic [7:0] lc3b_byte;

    // one 128-bit cache line
    // words view for the read path, bytes view for masked writes
    // words[n] and bytes[2n+1:2n] overlay the same bits
    typedef union packed {
        lc3b_word [7:0]  words;   // word select = offset[3:1]
        lc3b_byte [15:0] bytes;   // byte select = offset[3:0]
    } lc3b_cacheline;

endpackage : lc3b_types

//--- cache_types.sv
`include "cache_cfg.svh"

package cache_types;

    // address split for the direct-mapped L1, msb first
    typedef struct packed {
        logic [`TAG_W-1:0]    tag;
        logic [`INDEX_W-1:0]  index;
        logic [`OFFSET_W-1:0] offset;   // upper bits pick the word
    } cache_addr_t;

    // current owner of the pmem port
    typedef enum logic [1:0] {
        GNT_NONE,   // idle, free to grant
        GNT_D,      // data side (through eviction buffer)
        GNT_I       // instruction cache
    } grant_t;

endpackage : cache_types

//--- mem_if.sv
`timescale 1ns/1ns

// one request/response memory link
// request held until a one-cycle resp pulse
interface mem_if;

    logic                      read;      // line read request
    logic                      write;     // line write request
    lc3b_types::lc3b_word      address;   // line aligned on the lower links
    lc3b_types::lc3b_cacheline wdata;
    logic                      resp;      // single-cycle completion
    lc3b_types::lc3b_cacheline rdata;     // valid with resp

    modport requester (
        output read, write, address, wdata,
        input  resp, rdata
    );

    modport responder (
        input  read, write, address, wdata,
        output resp, rdata
    );

endinterface : mem_if

//--- l1_cache.sv
`timescale 1ns/1ns
`include "cache_cfg.svh"

// direct-mapped L1, one line per set
// WRITABLE=1 gives write-back with byte enables
// WRITABLE=0 is read only and never evicts
module l1_cache #(
    parameter bit WRITABLE = 1'b1
) (
    input  logic                      clk,
    input  logic                      i_rst_n,

    // core side, word granular
    input  logic                      i_mem_read,
    input  logic                      i_mem_write,
    input  lc3b_types::lc3b_mem_wmask i_mem_byte_enable,
    input  lc3b_types::lc3b_word      i_mem_address,
    input  lc3b_types::lc3b_word      i_mem_wdata,
    output logic                      o_mem_resp,
    output lc3b_types::lc3b_word      o_mem_rdata,

    // line side toward buffer or arbiter
    mem_if.requester                  lower
);

    typedef enum logic [1:0] {
        S_IDLE,        // lookup, hits served here
        S_WRITEBACK,   // dirty victim out
        S_FILL         // new line in, then replay
    } state_t;

    state_t state;

    // per-set arrays
    logic [`TAG_W-1:0]         tag_arr  [`L1_SETS];
    lc3b_types::lc3b_cacheline data_arr [`L1_SETS];
    logic [`L1_SETS-1:0]       valid_arr;
    logic [`L1_SETS-1:0]       dirty_arr;

    cache_types::cache_addr_t  addr;          // core address, split
    cache_types::cache_addr_t  victim_addr;   // line being written back
    cache_types::cache_addr_t  fill_addr;     // line being fetched
    logic [`INDEX_W-1:0]       idx;
    logic [`OFFSET_W-2:0]      word_sel;      // word within line
    logic                      wr_req;
    logic                      req;
    logic                      hit;
    logic                      accept;        // hit served this cycle
    lc3b_types::lc3b_cacheline cur_line;
    lc3b_types::lc3b_cacheline wr_line;       // cur_line with bytes merged

    assign addr     = i_mem_address;
    assign idx      = addr.index;
    assign word_sel = addr.offset[`OFFSET_W-1:1];   // drop byte bit
    assign wr_req   = WRITABLE && i_mem_write;      // tied off for the i-cache
    assign req      = i_mem_read || wr_req;
    assign cur_line = data_arr[idx];
    assign hit      = valid_arr[idx] && (tag_arr[idx] == addr.tag);

    // o_mem_resp high means the held request was just answered, skip it
    assign accept = (state == S_IDLE) && req && hit && !o_mem_resp;

    // byte merge through the bytes view
    always_comb begin
        wr_line = cur_line;
        if (i_mem_byte_enable[0]) begin
            wr_line.bytes[{word_sel, 1'b0}] = i_mem_wdata[7:0];    // low byte
        end
        if (i_mem_byte_enable[1]) begin
            wr_line.bytes[{word_sel, 1'b1}] = i_mem_wdata[15:8];   // high byte
        end
    end

    // line addresses for the lower link
    always_comb begin
        victim_addr        = addr;
        victim_addr.tag    = tag_arr[idx];   // stored tag, same set
        victim_addr.offset = '0;
        fill_addr          = addr;
        fill_addr.offset   = '0;
    end

    // control state
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state      <= S_IDLE;
            o_mem_resp <= 1'b0;
            valid_arr  <= '0;
            dirty_arr  <= '0;
        end else begin
            o_mem_resp <= accept;   // fixed hit latency of 1
            case (state)
                S_IDLE: begin
                    if (accept && wr_req) begin
                        dirty_arr[idx] <= 1'b1;
                    end else if (req && !hit && !o_mem_resp) begin
                        // clean or invalid victim goes straight to fill
                        if (valid_arr[idx] && dirty_arr[idx]) begin
                            state <= S_WRITEBACK;
                        end else begin
                            state <= S_FILL;
                        end
                    end
                end
                S_WRITEBACK: begin
                    if (lower.resp) state <= S_FILL;   // victim taken
                end
                S_FILL: begin
                    if (lower.resp) begin
                        state          <= S_IDLE;   // replay hits next
                        valid_arr[idx] <= 1'b1;
                        dirty_arr[idx] <= 1'b0;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // data, tags and read word
    always_ff @(posedge clk) begin
        if (accept) begin
            o_mem_rdata <= cur_line.words[word_sel];
        end
        if (accept && wr_req) begin
            data_arr[idx] <= wr_line;
        end
        if ((state == S_FILL) && lower.resp) begin
            data_arr[idx] <= lower.rdata;
            tag_arr[idx]  <= addr.tag;
        end
    end

    // requests held by state until resp
    assign lower.read    = (state == S_FILL);
    assign lower.write   = WRITABLE && (state == S_WRITEBACK);
    assign lower.address = (state == S_WRITEBACK) ? victim_addr : fill_addr;
    assign lower.wdata   = cur_line;   // victim line, index held by core

endmodule : l1_cache

//--- eviction_buffer.sv
`timescale 1ns/1ns
`include "cache_cfg.svh"

// one-line write buffer under the d-cache
// write-backs complete at once, drained when the lower link is free
// reads go first, a read of the held line is served locally
module eviction_buffer (
    input  logic     clk,
    input  logic     i_rst_n,
    mem_if.responder upper,   // from d-cache
    mem_if.requester lower    // to arbiter
);

    typedef enum logic [1:0] {
        L_IDLE,    // lower link free
        L_READ,    // forwarded read in flight
        L_DRAIN    // buffered line going out
    } lo_state_t;

    lo_state_t                 lo_state;
    logic                      full;       // buffer holds a line
    lc3b_types::lc3b_word      buf_addr;
    lc3b_types::lc3b_cacheline buf_line;
    logic                      rd_hit;     // read of the buffered line
    logic                      wr_accept;
    logic                      hit_accept;

    assign rd_hit = full && upper.read &&
                    (upper.address[15:`OFFSET_W] == buf_addr[15:`OFFSET_W]);

    // upper.resp high marks the answered cycle of a held request
    assign wr_accept  = upper.write && !full && !upper.resp;
    assign hit_accept = rd_hit && !upper.resp && (lo_state != L_READ);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            lo_state   <= L_IDLE;
            full       <= 1'b0;
            upper.resp <= 1'b0;
        end else begin
            upper.resp <= wr_accept || hit_accept;
            if (wr_accept) full <= 1'b1;   // full write waits for the drain
            case (lo_state)
                L_IDLE: begin
                    if (upper.read && !upper.resp && !rd_hit) begin
                        lo_state <= L_READ;    // reads ahead of drain
                    end else if (full) begin
                        lo_state <= L_DRAIN;
                    end
                end
                L_READ: begin
                    if (lower.resp) begin
                        lo_state   <= L_IDLE;
                        upper.resp <= 1'b1;   // pass completion up
                    end
                end
                L_DRAIN: begin
                    if (lower.resp) begin
                        lo_state <= L_IDLE;
                        full     <= 1'b0;     // memory now current
                    end
                end
                default: lo_state <= L_IDLE;
            endcase
        end
    end

    // line storage and returned data
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            buf_addr <= upper.address;
            buf_line <= upper.wdata;
        end
        if (hit_accept) begin
            upper.rdata <= buf_line;          // forwarded from buffer
        end else if ((lo_state == L_READ) && lower.resp) begin
            upper.rdata <= lower.rdata;
        end
    end

    assign lower.read    = (lo_state == L_READ);
    assign lower.write   = (lo_state == L_DRAIN);
    assign lower.address = (lo_state == L_READ) ? upper.address : buf_addr;
    assign lower.wdata   = buf_line;

endmodule : eviction_buffer

//--- arbiter.sv
`timescale 1ns/1ns

// fixed priority, data side first
// registered grant, registered pmem request and registered resp
module arbiter (
    input  logic                      clk,
    input  logic                      i_rst_n,
    mem_if.responder                  d_port,
    mem_if.responder                  i_port,

    output logic                      o_pmem_read,
    output logic                      o_pmem_write,
    output lc3b_types::lc3b_word      o_pmem_address,
    output lc3b_types::lc3b_cacheline o_pmem_wdata,
    input  logic                      i_pmem_resp,
    input  lc3b_types::lc3b_cacheline i_pmem_rdata
);

    cache_types::grant_t grant;
    logic                d_req;
    logic                i_req;

    // masked on the resp cycle, request still up then
    assign d_req = (d_port.read || d_port.write) && !d_port.resp;
    assign i_req = (i_port.read || i_port.write) && !i_port.resp;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            grant        <= cache_types::GNT_NONE;
            o_pmem_read  <= 1'b0;
            o_pmem_write <= 1'b0;
            d_port.resp  <= 1'b0;
            i_port.resp  <= 1'b0;
        end else begin
            d_port.resp <= (grant == cache_types::GNT_D) && i_pmem_resp;   // steered
            i_port.resp <= (grant == cache_types::GNT_I) && i_pmem_resp;
            case (grant)
                cache_types::GNT_NONE: begin
                    o_pmem_read  <= 1'b0;
                    o_pmem_write <= 1'b0;
                    if (d_req) begin
                        grant <= cache_types::GNT_D;
                    end else if (i_req) begin
                        grant <= cache_types::GNT_I;
                    end
                end
                cache_types::GNT_D: begin
                    if (i_pmem_resp) begin
                        grant        <= cache_types::GNT_NONE;   // release
                        o_pmem_read  <= 1'b0;
                        o_pmem_write <= 1'b0;
                    end else begin
                        o_pmem_read  <= d_port.read;
                        o_pmem_write <= d_port.write;
                    end
                end
                cache_types::GNT_I: begin
                    if (i_pmem_resp) begin
                        grant        <= cache_types::GNT_NONE;
                        o_pmem_read  <= 1'b0;
                        o_pmem_write <= 1'b0;
                    end else begin
                        o_pmem_read  <= i_port.read;
                        o_pmem_write <= i_port.write;
                    end
                end
                default: grant <= cache_types::GNT_NONE;
            endcase
        end
    end

    // payload copies, owner holds them stable
    always_ff @(posedge clk) begin
        if (grant == cache_types::GNT_D) begin
            o_pmem_address <= d_port.address;
            o_pmem_wdata   <= d_port.wdata;
        end else if (grant == cache_types::GNT_I) begin
            o_pmem_address <= i_port.address;
            o_pmem_wdata   <= i_port.wdata;
        end
        if (i_pmem_resp && (grant == cache_types::GNT_D)) d_port.rdata <= i_pmem_rdata;
        if (i_pmem_resp && (grant == cache_types::GNT_I)) i_port.rdata <= i_pmem_rdata;
    end

endmodule : arbiter

//--- mem_hier.sv
`timescale 1ns/1ns

// L1 I and D caches, eviction buffer and arbiter onto one pmem port
module mem_hier (
    input  logic                      clk,
    input  logic                      i_rst_n,

    // instruction fetch
    input  logic                      i_imem_read,
    input  lc3b_types::lc3b_word      i_imem_address,
    output logic                      o_imem_resp,
    output lc3b_types::lc3b_word      o_imem_rdata,

    // data access
    input  logic                      i_dmem_read,
    input  logic                      i_dmem_write,
    input  lc3b_types::lc3b_mem_wmask i_dmem_byte_enable,
    input  lc3b_types::lc3b_word      i_dmem_address,
    input  lc3b_types::lc3b_word      i_dmem_wdata,
    output logic                      o_dmem_resp,
    output lc3b_types::lc3b_word      o_dmem_rdata,

    // physical memory
    output logic                      o_pmem_read,
    output logic                      o_pmem_write,
    output lc3b_types::lc3b_word      o_pmem_address,
    output lc3b_types::lc3b_cacheline o_pmem_wdata,
    input  logic                      i_pmem_resp,
    input  lc3b_types::lc3b_cacheline i_pmem_rdata
);

    mem_if imem_link ();    // i-cache to arbiter
    mem_if dmem_link ();    // d-cache to buffer
    mem_if evict_link ();   // buffer to arbiter

    // read only, write side tied off
    l1_cache #(.WRITABLE(1'b0)) i_cache (
        .clk, .i_rst_n,
        .i_mem_read(i_imem_read), .i_mem_write(1'b0),
        .i_mem_byte_enable(2'b11), .i_mem_address(i_imem_address),
        .i_mem_wdata(16'h0000),
        .o_mem_resp(o_imem_resp), .o_mem_rdata(o_imem_rdata),
        .lower(imem_link.requester)
    );

    l1_cache #(.WRITABLE(1'b1)) d_cache (
        .clk, .i_rst_n,
        .i_mem_read(i_dmem_read), .i_mem_write(i_dmem_write),
        .i_mem_byte_enable(i_dmem_byte_enable), .i_mem_address(i_dmem_address),
        .i_mem_wdata(i_dmem_wdata),
        .o_mem_resp(o_dmem_resp), .o_mem_rdata(o_dmem_rdata),
        .lower(dmem_link.requester)
    );

    eviction_buffer eviction_buffer_inst (
        .clk, .i_rst_n,
        .upper(dmem_link.responder),
        .lower(evict_link.requester)
    );

    arbiter arbiter_inst (
        .clk, .i_rst_n,
        .d_port(evict_link.responder),   // wins ties
        .i_port(imem_link.responder),
        .o_pmem_read, .o_pmem_write, .o_pmem_address, .o_pmem_wdata,
        .i_pmem_resp, .i_pmem_rdata
    );

endmodule : mem_hier

//--- mem_hier_asserts.sv
`timescale 1ns/1ns

// handshake checks on the mem_hier boundary, bound into the top level
module mem_hier_asserts (
    input logic                      clk,
    input logic                      i_rst_n,
    input logic                      i_pmem_read,
    input logic                      i_pmem_write,
    input lc3b_types::lc3b_word      i_pmem_address,
    input lc3b_types::lc3b_cacheline i_pmem_wdata,
    input logic                      i_pmem_resp,
    input logic                      i_imem_resp,
    input logic                      i_dmem_resp,
    input cache_types::grant_t       i_grant   // arbiter owner register
);

    int n_fail = 0;   // failed assertion count, read by the testbench top

    // one direction at a time on pmem
    pmem_one_op: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(i_pmem_read && i_pmem_write))
        else begin
            n_fail++;
            $error("pmem read and write high together");
        end

    pmem_read_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_pmem_read && !i_pmem_resp) |=> (i_pmem_read && $stable(i_pmem_address)))
        else begin
            n_fail++;
            $error("pmem read dropped or moved before resp");
        end

    // write payload held too
    pmem_write_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_pmem_write && !i_pmem_resp) |=>
        (i_pmem_write && $stable(i_pmem_address) && $stable(i_pmem_wdata)))
        else begin
            n_fail++;
            $error("pmem write dropped or moved before resp");
        end

    resp_low_in_reset: assert property (@(posedge clk)
        !i_rst_n |-> !(i_imem_resp || i_dmem_resp))
        else begin
            n_fail++;
            $error("core resp high during reset");
        end

    // owner only moves from idle or on the completing cycle
    grant_switch: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_grant != $past(i_grant)) |->
        (($past(i_grant) == cache_types::GNT_NONE) || $past(i_pmem_resp)))
        else begin
            n_fail++;
            $error("arbiter grant changed mid transfer");
        end

endmodule : mem_hier_asserts

//--- tb_clk_gen.sv
`timescale 1ns/1ns

// free-running testbench clock and power-on reset
module tb_clk_gen #(
    parameter int HALF_PERIOD = 2,   // 4 ns clock
    parameter int RST_CYCLES  = 4    // reset held this many rising edges
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

    initial begin
        o_rst_n = 1'b1;
        #1;
        o_rst_n = 1'b0;   // real falling edge for the async reset
        repeat (RST_CYCLES) @(posedge o_clk);
        #1;
        o_rst_n = 1'b1;
    end

endmodule : tb_clk_gen

//--- tb_mem_hier.sv
`timescale 1ns/1ns

// concurrent random I and D traffic against a line memory and a byte model
module tb_mem_hier;

    localparam int N_DATA  = 300;                                // data operations
    localparam int N_FETCH = 200;                                // instruction fetches
    localparam int LIMIT   = (2 * N_DATA + N_FETCH + 8) * 400;   // cycle budget

    logic                      clk;
    logic                      i_rst_n;
    logic                      i_imem_read;
    lc3b_types::lc3b_word      i_imem_address;
    logic                      o_imem_resp;
    lc3b_types::lc3b_word      o_imem_rdata;
    logic                      i_dmem_read;
    logic                      i_dmem_write;
    lc3b_types::lc3b_mem_wmask i_dmem_byte_enable;
    lc3b_types::lc3b_word      i_dmem_address;
    lc3b_types::lc3b_word      i_dmem_wdata;
    logic                      o_dmem_resp;
    lc3b_types::lc3b_word      o_dmem_rdata;
    logic                      o_pmem_read;
    logic                      o_pmem_write;
    lc3b_types::lc3b_word      o_pmem_address;
    lc3b_types::lc3b_cacheline o_pmem_wdata;
    logic                      i_pmem_resp;
    lc3b_types::lc3b_cacheline i_pmem_rdata;

    lc3b_types::lc3b_cacheline pmem [lc3b_types::lc3b_word];   // written-back lines only
    logic [7:0]                ref_bytes [0:32767];              // data region, byte model
    logic [15:0]               lfsr = 16'd52;
    int err_data = 0;
    int err_fetch = 0;
    int err_lat = 0;
    int err_mem = 0;
    int cycles = 0;

    tb_clk_gen clk_gen_inst (.o_clk(clk), .o_rst_n(i_rst_n));
    mem_hier mem_hier_inst (.*);

    bind mem_hier mem_hier_asserts mem_hier_asserts_inst (
        .clk, .i_rst_n, .i_pmem_resp,
        .i_pmem_read(o_pmem_read), .i_pmem_write(o_pmem_write),
        .i_pmem_address(o_pmem_address), .i_pmem_wdata(o_pmem_wdata),
        .i_imem_resp(o_imem_resp), .i_dmem_resp(o_dmem_resp),
        .i_grant(arbiter_inst.grant)
    );

    // preload pattern, every address bit matters
    function automatic lc3b_types::lc3b_word init_word(input lc3b_types::lc3b_word a);
        return {a[7:0], a[15:8]} + 16'h3c5a;
    endfunction

    function automatic lc3b_types::lc3b_cacheline init_line(input lc3b_types::lc3b_word a);
        lc3b_types::lc3b_cacheline l;
        for (int w = 0; w < 8; w++) l.words[w] = init_word({a[15:4], w[2:0], 1'b0});
        return l;
    endfunction

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsr_next(lfsr);   // one step per bit
            v    = {v[14:0], lfsr[0]};
        end
    endtask

    function automatic lc3b_types::lc3b_word model_word(input lc3b_types::lc3b_word a);
        return {ref_bytes[{a[14:1], 1'b1}], ref_bytes[{a[14:1], 1'b0}]};   // little endian
    endfunction

    // one core data request held until resp, lat counts cycles to resp
    task automatic dmem_access(input logic rd, input logic wr,
                               input lc3b_types::lc3b_mem_wmask be,
                               input lc3b_types::lc3b_word a, input lc3b_types::lc3b_word wd,
                               output lc3b_types::lc3b_word q, output int lat);
        lat                = -1;   // first negedge is still the issue cycle
        i_dmem_read        = rd;
        i_dmem_write       = wr;
        i_dmem_byte_enable = be;
        i_dmem_address     = a;
        i_dmem_wdata       = wd;
        do begin
            @(negedge clk);
            lat++;
        end while (!o_dmem_resp);
        q = o_dmem_rdata;
        @(posedge clk);
        #1;
        i_dmem_read  = 1'b0;
        i_dmem_write = 1'b0;
    endtask

    task automatic read_check(input lc3b_types::lc3b_word a, output int lat);
        lc3b_types::lc3b_word q;
        dmem_access(1'b1, 1'b0, 2'b11, a, 16'h0000, q, lat);
        if (q !== model_word(a)) begin
            err_data++;
            $display("[ERROR] o_dmem_rdata @%h: got %h exp %h", a, q, model_word(a));
        end
    endtask

    task automatic write_word(input lc3b_types::lc3b_mem_wmask be,
                              input lc3b_types::lc3b_word a, input lc3b_types::lc3b_word wd);
        lc3b_types::lc3b_word q;
        int lat;
        if (be[0]) ref_bytes[{a[14:1], 1'b0}] = wd[7:0];   // model moves at issue
        if (be[1]) ref_bytes[{a[14:1], 1'b1}] = wd[15:8];
        dmem_access(1'b0, 1'b1, be, a, wd, q, lat);
    endtask

    task automatic run_data();
        logic [15:0] r;
        lc3b_types::lc3b_word a;
        lc3b_types::lc3b_word wd;
        int lat;
        for (int k = 0; k < N_DATA; k++) begin
            rand_bits(9, r);
            a = {1'b0, r[8:6], 5'b00000, r[5:0], 1'b0};   // 64 lines, 8 tags per set
            rand_bits(16, wd);
            rand_bits(3, r);
            case (r[1:0])
                2'd0: read_check(a, lat);
                2'd1: write_word(2'b11, a, wd);
                2'd2: begin
                    write_word(r[2] ? 2'b10 : 2'b01, a, wd);   // one byte only
                    read_check(a, lat);
                end
                default: begin
                    read_check(a, lat);
                    read_check(a, lat);   // line present now
                    if (lat != 1) begin
                        err_lat++;
                        $display("[ERROR] o_dmem_resp latency @%h: got %h exp %h", a, lat, 1);
                    end
                end
            endcase
        end
    endtask

    task automatic run_fetch();
        logic [15:0] r;
        lc3b_types::lc3b_word a;
        for (int k = 0; k < N_FETCH; k++) begin
            rand_bits(8, r);
            a              = {1'b1, 6'b000000, r[7:0], 1'b0};   // 32 lines above 0x8000
            i_imem_address = a;
            i_imem_read    = 1'b1;
            do @(negedge clk); while (!o_imem_resp);
            if (o_imem_rdata !== init_word(a)) begin
                err_fetch++;
                $display("[ERROR] o_imem_rdata @%h: got %h exp %h", a, o_imem_rdata, init_word(a));
            end
            @(posedge clk);
            #1;
            i_imem_read = 1'b0;
        end
    endtask

    // physical memory, 1 to 8 cycles per request
    initial begin : pmem_model
        logic [15:0] lat;
        i_pmem_resp  = 1'b0;
        i_pmem_rdata = '0;
        forever begin
            @(negedge clk);
            if (o_pmem_read || o_pmem_write) begin
                rand_bits(3, lat);
                repeat (lat + 1) @(posedge clk);
                #1;
                if (o_pmem_write) pmem[o_pmem_address] = o_pmem_wdata;
                else i_pmem_rdata = pmem.exists(o_pmem_address) ?
                                    pmem[o_pmem_address] : init_line(o_pmem_address);
                i_pmem_resp = 1'b1;
                @(posedge clk);
                #1;
                i_pmem_resp = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout: run still busy after %0d cycles", LIMIT);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        int lat;
        int n_assert;
        lc3b_types::lc3b_word iw;
        i_imem_read        = 1'b0;
        i_imem_address     = 16'h8000;
        i_dmem_read        = 1'b0;
        i_dmem_write       = 1'b0;
        i_dmem_byte_enable = 2'b11;
        i_dmem_address     = 16'h0000;
        i_dmem_wdata       = 16'h0000;
        for (int a = 0; a < 32768; a += 2) begin
            iw               = init_word(a[15:0]);
            ref_bytes[a]     = iw[7:0];
            ref_bytes[a + 1] = iw[15:8];
        end
        wait (i_rst_n === 1'b0);   // reset pulse starts after time 0
        @(posedge i_rst_n);
        @(posedge clk);
        #1;
        fork
            run_data();
            run_fetch();
        join
        // unused tag in every set pushes all dirty lines out
        for (int s = 0; s < 8; s++) read_check({8'h00, 1'b1, s[2:0], 4'h0}, lat);
        while (mem_hier_inst.eviction_buffer_inst.full) @(negedge clk);
        if (pmem.num() == 0) begin
            err_mem++;
            $display("no dirty line was ever written back to memory");
        end
        foreach (pmem[la]) begin
            for (int i = 0; i < 16; i++) begin
                if (pmem[la].bytes[i] !== ref_bytes[{la[14:4], i[3:0]}]) begin
                    err_mem++;
                    $display("[ERROR] o_pmem_wdata line %h byte %h: got %h exp %h", la, i[3:0],
                             pmem[la].bytes[i], ref_bytes[{la[14:4], i[3:0]}]);
                end
            end
        end
        n_assert = mem_hier_inst.mem_hier_asserts_inst.n_fail;
        $display("errors: data %0d, fetch %0d, latency %0d, memory %0d, assertions %0d",
                 err_data, err_fetch, err_lat, err_mem, n_assert);
        if (err_data + err_fetch + err_lat + err_mem + n_assert == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule : tb_mem_hier

//--- sim.f
+incdir+.
lc3b_types.sv
cache_types.sv
mem_if.sv
l1_cache.sv
eviction_buffer.sv
arbiter.sv
mem_hier.sv
mem_hier_asserts.sv
tb_clk_gen.sv
tb_mem_hier.sv

//--- Bender.yml
package:
  name: mem_hier

sources:
  - include_dirs:
      - .
    files:
      - lc3b_types.sv
      - cache_types.sv
      - mem_if.sv
      - l1_cache.sv
      - eviction_buffer.sv
      - arbiter.sv
      - mem_hier.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - mem_hier_asserts.sv
      - tb_clk_gen.sv
      - tb_mem_hier.sv
